/* src/cpuTypesPkg.sv */
`default_nettype none

package cpuTypesPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [15:0] immT;

    localparam wordT resetPc = 32'h0000_0000;
    localparam regAddrT linkReg = 5'd31; // JAL return address register
    localparam int regCount = 32;

    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        SLTIU = 6'b001011,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcodeT;

    typedef enum logic [5:0] {
        SLLV = 6'b000100,
        SRLV = 6'b000110,
        JR   = 6'b001000,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } functT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluNor, aluSlt, aluSltu, aluSll, aluSrl
    } aluOpT;

    typedef enum logic [1:0] {jumpNone, jumpTarget, jumpReg} jumpSelT;

    typedef enum logic [1:0] {wbAlu, wbLink, wbMem, wbLui} wbSelT;

    typedef struct packed {
        jumpSelT jumpSel;
        logic    link;      // Write address forced to linkReg
        logic    regDst;    // rd when set, rt otherwise
        logic    regWr;
        logic    aluSrc;    // Immediate as operand B
        aluOpT   aluCtr;
        wbSelT   wbSel;
        logic    extSigned;
        logic    halt;
        logic    dmemRen;
        logic    dmemWen;
        logic    branchEq;
        logic    branchNe;
    } controlT;

endpackage

`default_nettype wire

/* src/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  cpuTypesPkg::opcodeT  opcode,
    input  cpuTypesPkg::functT   funct,
    output cpuTypesPkg::controlT ctrl
);

    import cpuTypesPkg::*;

    always_comb begin
        ctrl.jumpSel = jumpNone;
        ctrl.link = 1'b0;
        ctrl.regDst = 1'b0;
        ctrl.regWr = 1'b0;
        ctrl.aluSrc = 1'b0;
        ctrl.aluCtr = aluAdd;
        ctrl.wbSel = wbAlu;
        ctrl.extSigned = 1'b1;
        ctrl.halt = 1'b0;
        ctrl.dmemRen = 1'b0;
        ctrl.dmemWen = 1'b0;
        ctrl.branchEq = 1'b0;
        ctrl.branchNe = 1'b0;
        case (opcode)
            RTYPE: begin
                ctrl.regDst = 1'b1;
                ctrl.regWr = 1'b1;
                case (funct)
                    ADDU, ADD: ctrl.aluCtr = aluAdd; // No overflow trap
                    SUBU, SUB: ctrl.aluCtr = aluSub;
                    AND: ctrl.aluCtr = aluAnd;
                    OR: ctrl.aluCtr = aluOr;
                    XOR: ctrl.aluCtr = aluXor;
                    NOR: ctrl.aluCtr = aluNor;
                    SLT: ctrl.aluCtr = aluSlt;
                    SLTU: ctrl.aluCtr = aluSltu;
                    SLLV: ctrl.aluCtr = aluSll;
                    SRLV: ctrl.aluCtr = aluSrl;
                    JR: begin
                        ctrl.regWr = 1'b0;
                        ctrl.jumpSel = jumpReg;
                    end
                    default: ctrl.regWr = 1'b0; // Unknown function, no effect
                endcase
            end

            ADDIU, ADDI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            ANDI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtr = aluAnd;
                ctrl.extSigned = 1'b0;
            end
            ORI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtr = aluOr;
                ctrl.extSigned = 1'b0;
            end
            XORI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtr = aluXor;
                ctrl.extSigned = 1'b0;
            end
            SLTI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtr = aluSlt;
            end
            SLTIU: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluCtr = aluSltu;
            end
            LUI: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.wbSel = wbLui;
            end
            LW: begin
                ctrl.regWr = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.dmemRen = 1'b1;
                ctrl.wbSel = wbMem;
            end
            SW: begin
                ctrl.aluSrc = 1'b1;
                ctrl.dmemWen = 1'b1;
            end
            BEQ: begin
                ctrl.aluCtr = aluSub; // zero flag compares rs and rt
                ctrl.branchEq = 1'b1;
            end
            BNE: begin
                ctrl.aluCtr = aluSub;
                ctrl.branchNe = 1'b1;
            end

            J: ctrl.jumpSel = jumpTarget;
            JAL: begin
                ctrl.jumpSel = jumpTarget;
                ctrl.regWr = 1'b1;
                ctrl.link = 1'b1;
                ctrl.wbSel = wbLink;
            end

            HALT: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        memExclusive: assert (!(ctrl.dmemRen && ctrl.dmemWen))
            else $error("Load and store decoded together");
    end

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  cpuTypesPkg::aluOpT aluCtr,
    input  cpuTypesPkg::wordT  portA,
    input  cpuTypesPkg::wordT  portB,
    output cpuTypesPkg::wordT  result,
    output logic               zero
);

    import cpuTypesPkg::*;

    logic [4:0] shamt;

    assign shamt = portA[4:0]; // Variable shifts take the amount from rs

    always_comb begin
        case (aluCtr)
            aluAdd: result = portA + portB;
            aluSub: result = portA - portB;
            aluAnd: result = portA & portB;
            aluOr: result = portA | portB;
            aluXor: result = portA ^ portB;
            aluNor: result = ~(portA | portB);
            aluSlt: result = wordT'($signed(portA) < $signed(portB));
            aluSltu: result = wordT'(portA < portB);
            aluSll: result = portB << shamt;
            aluSrl: result = portB >> shamt;
            default: result = '0;
        endcase
    end

    // Branch compare relies on this after aluSub
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 wen,
    input  cpuTypesPkg::regAddrT waddr,
    input  cpuTypesPkg::regAddrT raddrA,
    input  cpuTypesPkg::regAddrT raddrB,
    input  cpuTypesPkg::wordT    wdata,
    output cpuTypesPkg::wordT    rdataA,
    output cpuTypesPkg::wordT    rdataB
);

    import cpuTypesPkg::*;

    wordT regs [regCount];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    zeroRegFixed: assert property (@(posedge CLK) disable iff (rst) regs[0] == '0)
        else $error("Register 0 was written");

endmodule

`default_nettype wire

/* src/pcUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module pcUnit (
    input  logic                 CLK,
    input  logic                 rst,
    input  cpuTypesPkg::controlT ctrl,
    input  logic                 zero,
    input  cpuTypesPkg::wordT    instr,
    input  cpuTypesPkg::wordT    regTarget,
    output cpuTypesPkg::wordT    pc,
    output cpuTypesPkg::wordT    pcPlus4,
    output logic                 halted
);

    import cpuTypesPkg::*;

    wordT branchOffset;
    wordT jumpAddr;
    wordT nextPc;
    logic branchTaken;

    assign pcPlus4 = pc + 32'd4;
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpAddr = {pcPlus4[31:28], instr[25:0], 2'b00}; // Stays in the current region
    assign branchTaken = (ctrl.branchEq && zero) || (ctrl.branchNe && !zero);

    always_comb begin
        case (ctrl.jumpSel)
            jumpTarget: nextPc = jumpAddr;
            jumpReg: nextPc = regTarget;
            default: nextPc = branchTaken ? pcPlus4 + branchOffset : pcPlus4;
        endcase
    end

    // PC stays on the HALT word once it is decoded
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= resetPc;
            halted <= 1'b0;
        end else if (!halted) begin
            if (ctrl.halt) begin
                halted <= 1'b1;
            end else begin
                pc <= nextPc;
            end
        end
    end

    pcFrozen: assert property (@(posedge CLK) disable iff (rst) halted |=> $stable(pc))
        else $error("PC moved after halt");

endmodule

`default_nettype wire

/* src/singleCycleCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module singleCycleCpu (
    input  logic              CLK,
    input  logic              rst,
    output cpuTypesPkg::wordT imemAddr,
    input  cpuTypesPkg::wordT imemData,
    output cpuTypesPkg::wordT dmemAddr,
    output cpuTypesPkg::wordT dmemWdata,
    output logic              dmemRen,
    output logic              dmemWen,
    input  cpuTypesPkg::wordT dmemRdata,
    output logic              halted
);

    import cpuTypesPkg::*;

    controlT ctrl;
    wordT instr;
    wordT pc, pcPlus4;
    wordT rsData, rtData;
    wordT immExt, aluB, aluResult, wbData;
    immT imm;
    regAddrT rs, rt, rd, waddr;
    logic zero;

    // All-zero word decodes to nothing, so reset masks the fetch
    assign instr = rst ? '0 : imemData;
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign imm = instr[15:0];

    controlUnit decoder (
        .opcode(opcodeT'(instr[31:26])),
        .funct (functT'(instr[5:0])),
        .ctrl  (ctrl)
    );

    assign immExt = ctrl.extSigned ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign aluB = ctrl.aluSrc ? immExt : rtData;

    aluUnit alu (
        .aluCtr(ctrl.aluCtr),
        .portA (rsData),
        .portB (aluB),
        .result(aluResult),
        .zero  (zero)
    );

    assign waddr = ctrl.link ? linkReg : (ctrl.regDst ? rd : rt);

    always_comb begin
        case (ctrl.wbSel)
            wbLink: wbData = pcPlus4;
            wbMem: wbData = dmemRdata;
            wbLui: wbData = {imm, 16'h0000};
            default: wbData = aluResult;
        endcase
    end

    registerFile regFile (
        .CLK   (CLK),
        .rst   (rst),
        .wen   (ctrl.regWr && !halted),
        .waddr (waddr),
        .raddrA(rs),
        .raddrB(rt),
        .wdata (wbData),
        .rdataA(rsData),
        .rdataB(rtData)
    );

    pcUnit pcLogic (
        .CLK      (CLK),
        .rst      (rst),
        .ctrl     (ctrl),
        .zero     (zero),
        .instr    (instr),
        .regTarget(rsData),
        .pc       (pc),
        .pcPlus4  (pcPlus4),
        .halted   (halted)
    );

    assign imemAddr = pc;
    assign dmemAddr = aluResult;
    assign dmemWdata = rtData;
    assign dmemRen = ctrl.dmemRen;
    assign dmemWen = ctrl.dmemWen && !halted;

endmodule

`default_nettype wire

/* tb/cpuChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuChecker (
    input  logic              CLK,
    input  logic              rst,
    input  logic              endOfTest,
    input  cpuTypesPkg::wordT imemAddr,
    input  cpuTypesPkg::wordT dmemAddr,
    input  cpuTypesPkg::wordT dmemWdata,
    input  logic              dmemWen,
    input  logic              halted,
    output int                mismatchCount,
    output int                otherCount
);

    import cpuTypesPkg::*;

    localparam int storeCount = 19;
    localparam wordT haltAddr = 32'h0000_00BC; // HALT sits at word 47

    typedef struct packed {
        wordT addr;
        wordT data;
    } storeT;

    // Expected stores in program order
    string testNames [storeCount] = '{
        "addu", "subu", "and", "or", "xor", "nor", "slt", "sltu", "sllv", "srlv",
        "addiu", "ori", "xori", "andi", "lui", "swFirst", "lwBack", "bneFall", "jalLink"
    };
    storeT expStores [storeCount] = '{
        {32'h0000_0100, 32'hFFFF_FFFD}, {32'h0000_0104, 32'h0000_0011},
        {32'h0000_0108, 32'h0000_0006}, {32'h0000_010C, 32'hFFFF_FFF7},
        {32'h0000_0110, 32'hFFFF_FFF1}, {32'h0000_0114, 32'h0000_0008},
        {32'h0000_0118, 32'h0000_0001}, {32'h0000_011C, 32'h0000_0000},
        {32'h0000_0120, 32'hFFFF_FB00}, {32'h0000_0124, 32'h01FF_FFFF},
        {32'h0000_0128, 32'hFFFF_8000}, {32'h0000_012C, 32'h0000_8001},
        {32'h0000_0130, 32'hFFFF_7FF6}, {32'h0000_0134, 32'h0000_F0F0},
        {32'h0000_0138, 32'h1234_0000}, {32'h0000_013C, 32'h1234_5678},
        {32'h0000_0140, 32'h1234_5678}, {32'h0000_0148, 32'h0000_0007},
        {32'h0000_014C, 32'h0000_00AC}
    };

    int mmCount = 0;
    int errCount = 0;
    int storeIdx = 0;
    logic prevRst = 1'b1;

    assign mismatchCount = mmCount;
    assign otherCount = errCount;

    always @(posedge CLK) begin
        if (rst) begin
            if (dmemWen) begin
                $display("Data memory write enabled during reset");
                errCount++;
            end
            if (halted) begin
                $display("Halted is high during reset");
                errCount++;
            end
        end else begin
            if (prevRst && imemAddr != 32'h0000_0000) begin
                $display("First fetch after reset at %h instead of zero", imemAddr);
                errCount++;
            end
            if (dmemWen && storeIdx >= storeCount) begin
                $display("Unexpected write of %h to address %h", dmemWdata, dmemAddr);
                errCount++;
            end else if (dmemWen) begin
                if (dmemAddr != expStores[storeIdx].addr) begin
                    $display("Mismatch %s address: expected %h, actual %h",
                        testNames[storeIdx], expStores[storeIdx].addr, dmemAddr);
                    mmCount++;
                end
                if (dmemWdata != expStores[storeIdx].data) begin
                    $display("Mismatch %s data: expected %h, actual %h",
                        testNames[storeIdx], expStores[storeIdx].data, dmemWdata);
                    mmCount++;
                end
                storeIdx++;
            end
            if (halted && imemAddr != haltAddr) begin
                $display("PC left the halt instruction, now at %h", imemAddr);
                errCount++;
            end
        end
        if (endOfTest && storeIdx != storeCount) begin
            $display("Only %0d of %0d expected stores were seen", storeIdx, storeCount);
            errCount++;
        end
        prevRst <= rst;
    end

endmodule

`default_nettype wire

/* tb/cpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

    import cpuTypesPkg::*;

    localparam int resetCycles = 4;
    localparam int haltTimeout = 500;
    localparam int haltHoldCycles = 10;

    logic CLK = 1'b0;
    logic rst = 1'b1;
    logic endOfTest = 1'b0;
    wordT imemAddr, imemData;
    wordT dmemAddr, dmemWdata, dmemRdata;
    logic dmemRen, dmemWen, halted;
    int mismatchCount, otherCount;
    int timeoutCount = 0;

    wordT imem [64];
    wordT dmem [256];
    wordT progQ [$];

    always #5 CLK = ~CLK;

    // Combinational memory reads, data writes on the rising edge
    assign imemData = imem[imemAddr[7:2]];
    assign dmemRdata = dmemRen ? dmem[dmemAddr[9:2]] : 32'h0000_0000;

    always @(posedge CLK) begin
        if (dmemWen) begin
            dmem[dmemAddr[9:2]] <= dmemWdata;
        end
    end

    singleCycleCpu dut (
        .CLK      (CLK),
        .rst      (rst),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .dmemAddr (dmemAddr),
        .dmemWdata(dmemWdata),
        .dmemRen  (dmemRen),
        .dmemWen  (dmemWen),
        .dmemRdata(dmemRdata),
        .halted   (halted)
    );

    cpuChecker storeCheck (
        .CLK          (CLK),
        .rst          (rst),
        .endOfTest    (endOfTest),
        .imemAddr     (imemAddr),
        .dmemAddr     (dmemAddr),
        .dmemWdata    (dmemWdata),
        .dmemWen      (dmemWen),
        .halted       (halted),
        .mismatchCount(mismatchCount),
        .otherCount   (otherCount)
    );

    function automatic wordT rTypeWord(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
        return {RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iTypeWord(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpWord(opcodeT op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic buildProgram();
        progQ.push_back(iTypeWord(ADDIU, 1, 0, 16'hFFF6)); // r1 = -10
        progQ.push_back(iTypeWord(ORI, 2, 0, 16'h0007));   // r2 = 7
        progQ.push_back(rTypeWord(ADDU, 3, 1, 2));
        progQ.push_back(iTypeWord(SW, 3, 0, 16'h0100));
        progQ.push_back(rTypeWord(SUBU, 4, 2, 1));
        progQ.push_back(iTypeWord(SW, 4, 0, 16'h0104));
        progQ.push_back(rTypeWord(AND, 5, 1, 2));
        progQ.push_back(iTypeWord(SW, 5, 0, 16'h0108));
        progQ.push_back(rTypeWord(OR, 6, 1, 2));
        progQ.push_back(iTypeWord(SW, 6, 0, 16'h010C));
        progQ.push_back(rTypeWord(XOR, 7, 1, 2));
        progQ.push_back(iTypeWord(SW, 7, 0, 16'h0110));
        progQ.push_back(rTypeWord(NOR, 8, 1, 2));
        progQ.push_back(iTypeWord(SW, 8, 0, 16'h0114));
        progQ.push_back(rTypeWord(SLT, 9, 1, 2));
        progQ.push_back(iTypeWord(SW, 9, 0, 16'h0118));
        progQ.push_back(rTypeWord(SLTU, 10, 1, 2));
        progQ.push_back(iTypeWord(SW, 10, 0, 16'h011C));
        progQ.push_back(rTypeWord(SLLV, 11, 2, 1)); // r1 shifted by r2
        progQ.push_back(iTypeWord(SW, 11, 0, 16'h0120));
        progQ.push_back(rTypeWord(SRLV, 12, 2, 1));
        progQ.push_back(iTypeWord(SW, 12, 0, 16'h0124));
        progQ.push_back(iTypeWord(ADDIU, 13, 0, 16'h8000));
        progQ.push_back(iTypeWord(SW, 13, 0, 16'h0128));
        progQ.push_back(iTypeWord(ORI, 14, 0, 16'h8001));
        progQ.push_back(iTypeWord(SW, 14, 0, 16'h012C));
        progQ.push_back(iTypeWord(XORI, 15, 1, 16'h8000));
        progQ.push_back(iTypeWord(SW, 15, 0, 16'h0130));
        progQ.push_back(iTypeWord(ANDI, 16, 1, 16'hF0F0));
        progQ.push_back(iTypeWord(SW, 16, 0, 16'h0134));
        progQ.push_back(iTypeWord(LUI, 17, 0, 16'h1234));
        progQ.push_back(iTypeWord(SW, 17, 0, 16'h0138));
        progQ.push_back(iTypeWord(ORI, 18, 17, 16'h5678));
        progQ.push_back(iTypeWord(SW, 18, 0, 16'h013C));
        progQ.push_back(iTypeWord(LW, 19, 0, 16'h013C));
        progQ.push_back(iTypeWord(SW, 19, 0, 16'h0140));
        progQ.push_back(iTypeWord(BEQ, 2, 2, 16'h0001)); // Taken, skips next
        progQ.push_back(iTypeWord(SW, 1, 0, 16'h0144));
        progQ.push_back(iTypeWord(BNE, 2, 2, 16'h0001));
        progQ.push_back(iTypeWord(SW, 2, 0, 16'h0148));
        progQ.push_back(jumpWord(J, 26'd42));
        progQ.push_back(iTypeWord(SW, 1, 0, 16'h0154));
        progQ.push_back(jumpWord(JAL, 26'd45));          // Word 42, link 0xAC
        progQ.push_back(iTypeWord(SW, 31, 0, 16'h014C));
        progQ.push_back(jumpWord(J, 26'd47));
        progQ.push_back(rTypeWord(JR, 0, 31, 0));
        progQ.push_back(iTypeWord(SW, 1, 0, 16'h0158));
        progQ.push_back(jumpWord(HALT, 26'd0));          // Word 47
        progQ.push_back(iTypeWord(SW, 1, 0, 16'h015C));
    endtask

    initial begin
        int cycles;
        buildProgram();
        // Every word is a store until the program is loaded
        for (int i = 0; i < 64; i++) begin
            imem[i] = iTypeWord(SW, 0, 0, 16'h0200);
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hDA7A_0000 | (i * 4);
        end
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge CLK);
        end
        @(negedge CLK);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < progQ.size()) ? progQ[i] : 32'h0000_0000;
        end
        rst = 1'b0;

        cycles = 0;
        while (!halted && cycles < haltTimeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halted) begin
            $display("Core never halted within %0d cycles", haltTimeout);
            timeoutCount++;
        end
        for (int i = 0; i < haltHoldCycles; i++) begin
            @(negedge CLK);
        end
        endOfTest = 1'b1;
        @(negedge CLK);
        endOfTest = 1'b0;

        $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
            mismatchCount, otherCount, timeoutCount);
        if (mismatchCount + otherCount + timeoutCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.f */
src/cpuTypesPkg.sv
src/controlUnit.sv
src/aluUnit.sv
src/registerFile.sv
src/pcUnit.sv
src/singleCycleCpu.sv
tb/cpuChecker.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu.f --top-module cpuTb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0
